//--- design/axi_rd_pkg.sv
`include "engine_settings.svh"

package axi_rd_pkg;

    // read address channel, master side
    // size, burst type and the sideband fields are fixed
    // and live in the slave, so only these travel
    typedef struct packed {
        logic                valid;
        logic [`ADDR_W-1:0]  addr;
        logic [7:0]          len;       // beats - 1
    } ar_req_t;

    // read data channel, slave side
    typedef struct packed {
        logic                valid;
        logic                last;      // final beat of the burst
        logic [`DATA_W-1:0]  data;
    } r_beat_t;

    // incr burst, 4 bytes per beat
    localparam int BEAT_BYTES = `DATA_W / 8;

endpackage

//--- design/burst_reader.sv
`timescale 1ns/1ps
`include "engine_settings.svh"

module burst_reader (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_empty,
    input  load_pkg::load_desc_t  i_head,
    output logic                  o_pop,
    output axi_rd_pkg::ar_req_t   o_ar,
    input  logic                  i_ar_ready,
    input  axi_rd_pkg::r_beat_t   i_r,
    output logic                  o_r_ready,
    output load_pkg::load_word_t  o_load,
    output logic                  o_desc_done,
    output logic                  o_done_last
);
    import load_pkg::*;

    localparam int AW = `ADDR_W;
    localparam int BW = `BLK_W;

    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} rd_state_e;

    rd_state_e     state;
    load_target_e  cur_target;
    logic [AW-1:0] cur_addr;        // next block address
    logic [BW-1:0] blk_left;        // blocks not yet requested
    logic          cur_last;
    logic          ar_fire;
    logic          r_fire;
    logic          burst_end;

    assign ar_fire   = o_ar.valid && i_ar_ready;
    assign r_fire    = i_r.valid && o_r_ready;
    assign burst_end = r_fire && i_r.last;

    assign o_pop     = (state == R_IDLE) && !i_empty;
    assign o_r_ready = (state == R_DATA);     // high while a burst is open

    always_comb begin
        o_ar.valid = (state == R_ADDR);
        o_ar.addr  = cur_addr;
        o_ar.len   = 8'(`BURST_LEN - 1);
    end

    // combinational tag on every accepted beat
    always_comb begin
        o_load.valid  = r_fire;
        o_load.target = cur_target;
        o_load.data   = i_r.data;
    end

    // ---------------------------------------------------------------------------
    // one outstanding burst per 64-byte block
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= R_IDLE;
            o_desc_done <= 1'b0;
            o_done_last <= 1'b0;
        end else begin
            o_desc_done <= 1'b0;            // pulses
            o_done_last <= 1'b0;
            case (state)
                R_IDLE: if (o_pop) state <= R_ADDR;
                R_ADDR: if (ar_fire) state <= R_DATA;
                R_DATA: begin
                    if (burst_end) begin
                        if (blk_left == '0) begin
                            state       <= R_IDLE;
                            o_desc_done <= 1'b1;
                            o_done_last <= cur_last;
                        end else begin
                            state <= R_ADDR;      // next block
                        end
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // latch head on pop and step address and count per accepted ar
    always_ff @(posedge clk) begin
        if (o_pop) begin
            cur_target <= i_head.target;
            cur_addr   <= i_head.base;
            blk_left   <= i_head.blocks;
            cur_last   <= i_head.last;
        end else if (ar_fire) begin
            cur_addr <= cur_addr + AW'(`BLOCK_BYTES);
            blk_left <= blk_left - BW'(1);
        end
    end

    // r has no back-pressure so every beat must land in an open burst
    a_r_open: assert property (@(posedge clk) disable iff (!rstn)
        i_r.valid |-> o_r_ready);

    // ar valid and address held until the slave takes them
    a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_ar.valid && !i_ar_ready |=> o_ar.valid && $stable(o_ar.addr));

endmodule

//--- design/desc_fifo.sv
`timescale 1ns/1ps
`include "engine_settings.svh"

module desc_fifo (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_push,
    input  load_pkg::load_desc_t  i_desc,
    output logic                  o_full,
    input  logic                  i_pop,
    output logic                  o_empty,
    output load_pkg::load_desc_t  o_head
);
    import load_pkg::*;

    localparam int PTR_W = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    load_desc_t        mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    // circular wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    assign o_full  = (count == CNT_W'(`FIFO_DEPTH));
    assign o_empty = (count == '0);
    assign o_head  = mem[rd_ptr];      // show-ahead

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) wr_ptr <= ptr_next(wr_ptr);
            if (i_pop)  rd_ptr <= ptr_next(rd_ptr);
            case ({i_push, i_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;        // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) mem[wr_ptr] <= i_desc;
    end

    // both neighbours must honour the levels
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn) i_pop |-> !o_empty);
    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn) i_push |-> !o_full);

endmodule

//--- design/engine_settings.svh
`ifndef ENGINE_SETTINGS_SVH
`define ENGINE_SETTINGS_SVH

// ---------------------------------------------------------------------------
// bus widths and burst shape
// ---------------------------------------------------------------------------
`define ADDR_W         32
`define DATA_W         32
`define BURST_LEN      16       // beats per read burst
`define BLOCK_BYTES    64       // one burst of 32-bit beats

// byte offsets from the read base in dram
`define FILTER_OFFSET  4096
`define BIAS_OFFSET    8704     // filter region is 4608 bytes
`define SCALE_OFFSET   8832     // bias region is 128 bytes

// ---------------------------------------------------------------------------
// debug layer, 16x16 pixels
// ---------------------------------------------------------------------------
`define LAYER_CHN_IN   4        // input channel words
`define LAYER_CHN_OUT  8        // output channels
`define LAYER_FRAME    1024     // ifm words, 16*16*4
`define N_GROUPS       2        // output groups per run

`define BLK_W          16       // block count width
`define FIFO_DEPTH     4

`endif

//--- design/load_engine_top.sv
`timescale 1ns/1ps

module load_engine_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [31:0]           i_ctrl_reg0,
    input  logic [31:0]           i_ctrl_reg1,
    output axi_rd_pkg::ar_req_t   o_ar,
    input  logic                  i_ar_ready,
    input  axi_rd_pkg::r_beat_t   i_r,
    output logic                  o_r_ready,
    output load_pkg::load_word_t  o_load,
    output logic                  o_network_done
);
    import load_pkg::*;

    // sequencer -> fifo
    logic        push;
    logic        full;
    load_desc_t  push_desc;

    // fifo -> reader
    logic        pop;
    logic        empty;
    load_desc_t  head_desc;

    // reader -> sequencer
    logic        desc_done;
    logic        done_last;

    load_sequencer u_seq (
        .clk            (clk),
        .rstn           (rstn),
        .i_ctrl_reg0    (i_ctrl_reg0),
        .i_ctrl_reg1    (i_ctrl_reg1),
        .i_fifo_full    (full),
        .o_push         (push),
        .o_desc         (push_desc),
        .i_desc_done    (desc_done),
        .i_done_last    (done_last),
        .o_network_done (o_network_done)
    );

    desc_fifo u_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .i_push  (push),
        .i_desc  (push_desc),
        .o_full  (full),
        .i_pop   (pop),
        .o_empty (empty),
        .o_head  (head_desc)
    );

    burst_reader u_rd (
        .clk         (clk),
        .rstn        (rstn),
        .i_empty     (empty),
        .i_head      (head_desc),
        .o_pop       (pop),
        .o_ar        (o_ar),
        .i_ar_ready  (i_ar_ready),
        .i_r         (i_r),
        .o_r_ready   (o_r_ready),
        .o_load      (o_load),
        .o_desc_done (desc_done),
        .o_done_last (done_last)
    );

endmodule

//--- design/load_pkg.sv
`include "engine_settings.svh"

package load_pkg;

    // which on-chip buffer a load feeds
    typedef enum logic [1:0] {
        TGT_IFM    = 2'd0,
        TGT_FILTER = 2'd1,
        TGT_BIAS   = 2'd2,
        TGT_SCALE  = 2'd3
    } load_target_e;

    // one load job, sequencer -> fifo -> reader
    typedef struct packed {
        logic                last;      // final load of the run
        load_target_e        target;
        logic [`ADDR_W-1:0]  base;      // byte address of block 0
        logic [`BLK_W-1:0]   blocks;    // 64-byte blocks to fetch
    } load_desc_t;

    // tagged read word toward the buffers
    typedef struct packed {
        logic                valid;
        load_target_e        target;
        logic [`DATA_W-1:0]  data;
    } load_word_t;

endpackage

//--- design/load_sequencer.sv
`timescale 1ns/1ps
`include "engine_settings.svh"

module load_sequencer (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [31:0]           i_ctrl_reg0,     // bit 0 start
    input  logic [31:0]           i_ctrl_reg1,     // read base
    input  logic                  i_fifo_full,
    output logic                  o_push,
    output load_pkg::load_desc_t  o_desc,
    input  logic                  i_desc_done,
    input  logic                  i_done_last,
    output logic                  o_network_done
);
    import load_pkg::*;

    localparam int AW    = `ADDR_W;
    localparam int BW    = `BLK_W;
    localparam int GRP_W = $clog2(`N_GROUPS + 1);

    // byte sizes of one load
    localparam int IFM_BYTES    = `LAYER_FRAME * 4;
    localparam int FILTER_BYTES = `LAYER_CHN_IN * 16 * 9;    // 3x3 kernels
    localparam int AFFINE_BYTES = `LAYER_CHN_OUT * 16;       // bias or scale

    function automatic int ceil_blocks(input int nbytes);
        return (nbytes + `BLOCK_BYTES - 1) / `BLOCK_BYTES;
    endfunction

    localparam logic [BW-1:0] IFM_BLKS    = BW'(ceil_blocks(IFM_BYTES));     // 64
    localparam logic [BW-1:0] FILTER_BLKS = BW'(ceil_blocks(FILTER_BYTES));  // 9
    localparam logic [BW-1:0] AFFINE_BLKS = BW'(ceil_blocks(AFFINE_BYTES));  // 2

    typedef enum logic [2:0] {
        S_IDLE, S_IFM, S_FILTER, S_BIAS, S_SCALE, S_WAIT
    } seq_state_e;

    seq_state_e        state;
    logic [GRP_W-1:0]  grp;           // output group index
    logic              start_acc;
    logic              last_grp;
    logic              net_done;

    // per-target read bases advanced after each group load
    logic [AW-1:0]     base_ifm;
    logic [AW-1:0]     base_filter;
    logic [AW-1:0]     base_bias;
    logic [AW-1:0]     base_scale;

    assign start_acc = i_ctrl_reg0[0] && (state == S_IDLE);   // ignored while busy
    assign last_grp  = (grp == GRP_W'(`N_GROUPS - 1));
    assign o_push    = (state inside {S_IFM, S_FILTER, S_BIAS, S_SCALE}) && !i_fifo_full;
    assign o_network_done = net_done;

    // ---------------------------------------------------------------------------
    // ifm once then filter / bias / scale per group
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= S_IDLE;
            grp      <= '0;
            net_done <= 1'b0;
        end else begin
            if (start_acc)
                net_done <= 1'b0;
            else if (state == S_WAIT && i_desc_done && i_done_last)
                net_done <= 1'b1;         // held until next start

            case (state)
                S_IDLE: begin
                    if (start_acc) begin
                        state <= S_IFM;
                        grp   <= '0;
                    end
                end
                S_IFM:    if (o_push) state <= S_FILTER;
                S_FILTER: if (o_push) state <= S_BIAS;
                S_BIAS:   if (o_push) state <= S_SCALE;    // scale always follows bias
                S_SCALE: begin
                    if (o_push) begin
                        if (last_grp) begin
                            state <= S_WAIT;
                        end else begin
                            grp   <= grp + GRP_W'(1);
                            state <= S_FILTER;
                        end
                    end
                end
                S_WAIT:   if (i_desc_done && i_done_last) state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    // base derivation on start and per-load advance on push
    always_ff @(posedge clk) begin
        if (start_acc) begin
            base_ifm    <= i_ctrl_reg1;
            base_filter <= i_ctrl_reg1 + AW'(`FILTER_OFFSET);
            base_bias   <= i_ctrl_reg1 + AW'(`BIAS_OFFSET);
            base_scale  <= i_ctrl_reg1 + AW'(`SCALE_OFFSET);
        end else if (o_push) begin
            if (state == S_FILTER) base_filter <= base_filter + AW'(FILTER_BYTES);
            if (state == S_BIAS)   base_bias   <= base_bias + AW'(AFFINE_BYTES);
            if (state == S_SCALE)  base_scale  <= base_scale + AW'(AFFINE_BYTES);
        end
    end

    // descriptor for the current state
    always_comb begin
        o_desc = '0;
        case (state)
            S_IFM: begin
                o_desc.target = TGT_IFM;
                o_desc.base   = base_ifm;
                o_desc.blocks = IFM_BLKS;
            end
            S_FILTER: begin
                o_desc.target = TGT_FILTER;
                o_desc.base   = base_filter;
                o_desc.blocks = FILTER_BLKS;
            end
            S_BIAS: begin
                o_desc.target = TGT_BIAS;
                o_desc.base   = base_bias;
                o_desc.blocks = AFFINE_BLKS;
            end
            S_SCALE: begin
                o_desc.target = TGT_SCALE;
                o_desc.base   = base_scale;
                o_desc.blocks = AFFINE_BLKS;
                o_desc.last   = last_grp;         // final scale closes the run
            end
            default: o_desc = '0;
        endcase
    end

    // a full fifo freezes the schedule and the pending descriptor
    a_hold_full: assert property (@(posedge clk) disable iff (!rstn)
        i_fifo_full && (state inside {S_IFM, S_FILTER, S_BIAS, S_SCALE})
            |=> $stable(state) && $stable(o_desc));

endmodule

//--- run.sh
#!/bin/sh
# compile with verilator, run, then search the log for the failure line
verilator --binary --assert --timescale 1ns/1ps --top-module tb_load_engine -f sim.f \
    && ./obj_dir/Vtb_load_engine > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "TB FAILED" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed, see sim.log"; exit 1; }

//--- sim.f
+incdir+design
design/load_pkg.sv
design/axi_rd_pkg.sv
design/load_sequencer.sv
design/desc_fifo.sv
design/burst_reader.sv
design/load_engine_top.sv
verif/load_checker.sv
verif/tb_load_engine.sv

//--- verif/load_checker.sv
`timescale 1ns/1ps
`include "engine_settings.svh"

module load_checker (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [31:0]           i_ctrl_reg0,
    input  logic [31:0]           i_ctrl_reg1,
    input  axi_rd_pkg::ar_req_t   i_ar,
    input  axi_rd_pkg::r_beat_t   i_r,
    input  logic                  i_r_ready,
    input  load_pkg::load_word_t  i_load,
    input  logic                  i_network_done,
    output int                    o_errors,
    output int                    o_checked
);
    import load_pkg::*;

    // word counts per load from byte sizes rounded up to whole 64-byte blocks
    localparam int FILTER_BYTES = 576;
    localparam int AFFINE_BYTES = 128;      // bias or scale
    localparam int BLK_WORDS    = `BLOCK_BYTES / 4;
    localparam int IFM_WORDS    = `LAYER_FRAME;
    localparam int FILTER_WORDS = ((FILTER_BYTES + `BLOCK_BYTES - 1) / `BLOCK_BYTES) * BLK_WORDS;
    localparam int AFFINE_WORDS = ((AFFINE_BYTES + `BLOCK_BYTES - 1) / `BLOCK_BYTES) * BLK_WORDS;
    localparam int GRP_WORDS    = FILTER_WORDS + 2 * AFFINE_WORDS;
    localparam int RUN_WORDS    = IFM_WORDS + `N_GROUPS * GRP_WORDS;

    typedef struct packed {
        load_target_e  target;
        logic [31:0]   addr;
    } exp_word_t;

    exp_word_t  exp_q [$];      // words still owed by the current run
    logic       started;        // any start seen
    logic       busy;
    logic       done_seen;      // done must hold until next start

    // ------------------------------------------------------------------------
    // reference word idx of a run from its read base
    // ------------------------------------------------------------------------
    function automatic exp_word_t ref_word(input logic [31:0] base, input int idx);
        exp_word_t w;
        int        rem;
        int        g;
        rem = idx;
        if (rem < IFM_WORDS) begin
            w.target = TGT_IFM;
            w.addr   = base + 32'(4 * rem);
            return w;
        end
        rem = rem - IFM_WORDS;
        g   = rem / GRP_WORDS;                // output group
        rem = rem % GRP_WORDS;
        if (rem < FILTER_WORDS) begin
            w.target = TGT_FILTER;
            w.addr   = base + 32'(`FILTER_OFFSET + g * FILTER_BYTES + 4 * rem);
        end else if (rem < FILTER_WORDS + AFFINE_WORDS) begin
            rem      = rem - FILTER_WORDS;
            w.target = TGT_BIAS;              // group 1 lands on scale group 0
            w.addr   = base + 32'(`BIAS_OFFSET + g * AFFINE_BYTES + 4 * rem);
        end else begin
            rem      = rem - FILTER_WORDS - AFFINE_WORDS;
            w.target = TGT_SCALE;
            w.addr   = base + 32'(`SCALE_OFFSET + g * AFFINE_BYTES + 4 * rem);
        end
        return w;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("FAIL %0t %s expected 0x%08h got 0x%08h", $time, sig, want, got);
        o_errors++;
    endtask

    always @(posedge clk or negedge rstn) begin
        exp_word_t want;
        if (!rstn) begin
            started   = 1'b0;
            busy      = 1'b0;
            done_seen = 1'b0;
            o_errors  = 0;
            o_checked = 0;
        end else begin
            if (!started) begin                          // quiet before any start
                if (i_ar.valid)     report_mismatch("o_ar.valid", 32'd0, 32'(i_ar.valid));
                if (i_load.valid)   report_mismatch("o_load.valid", 32'd0, 32'(i_load.valid));
                if (i_r_ready)      report_mismatch("o_r_ready", 32'd0, 32'd1);
                if (i_network_done) report_mismatch("o_network_done", 32'd0, 32'd1);
            end
            if (i_ar.valid && i_ar.len !== 8'(`BURST_LEN - 1))
                report_mismatch("o_ar.len", 32'(`BURST_LEN - 1), 32'(i_ar.len));
            if (i_r.valid && !i_r_ready) begin
                $display("%0t: read beat presented while o_r_ready is low", $time);
                o_errors++;
            end
            if (i_load.valid) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: load word 0x%08h arrived with none expected",
                             $time, i_load.data);
                    o_errors++;
                end else begin
                    want = exp_q.pop_front();
                    if (i_load.target !== want.target)
                        report_mismatch("o_load.target", 32'(want.target), 32'(i_load.target));
                    if (i_load.data !== want.addr)
                        report_mismatch("o_load.data", want.addr, i_load.data);
                    o_checked++;
                end
            end
            if (busy && i_network_done) begin
                if (exp_q.size() != 0) begin
                    $display("%0t: network done raised with %0d words missing",
                             $time, exp_q.size());
                    o_errors++;
                end
                busy      = 1'b0;
                done_seen = 1'b1;
            end else if (done_seen && !i_network_done) begin
                $display("%0t: network done dropped without a new start", $time);
                o_errors++;
                done_seen = 1'b0;
            end
            // a start pulse during a run is ignored
            if (i_ctrl_reg0[0] && !busy) begin
                for (int i = 0; i < RUN_WORDS; i++)
                    exp_q.push_back(ref_word(i_ctrl_reg1, i));
                started   = 1'b1;
                busy      = 1'b1;
                done_seen = 1'b0;
            end
        end
    end

endmodule

//--- verif/tb_load_engine.sv
`timescale 1ns/1ps
`include "engine_settings.svh"

module tb_load_engine;
    import load_pkg::*;
    import axi_rd_pkg::*;

    localparam int RUN_WORDS = 1440;     // 1024 ifm + 2 x (144 + 32 + 32)
    localparam int TIMEOUT   = 15000;    // 2 runs x 90 blocks x 16 beats x 4 cycles + margin

    logic        clk;
    logic        rstn;
    logic [31:0] ctrl_reg0;
    logic [31:0] ctrl_reg1;
    ar_req_t     ar;
    logic        ar_ready;
    r_beat_t     r_beat;
    logic        r_ready;
    load_word_t  load_word;
    logic        network_done;
    int          chk_errors;
    int          chk_words;
    int          tb_errors = 0;
    int          cycles = 0;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    load_engine_top DUT (
        .clk(clk), .rstn(rstn), .i_ctrl_reg0(ctrl_reg0), .i_ctrl_reg1(ctrl_reg1),
        .o_ar(ar), .i_ar_ready(ar_ready), .i_r(r_beat), .o_r_ready(r_ready),
        .o_load(load_word), .o_network_done(network_done)
    );

    load_checker u_checker (
        .clk(clk), .rstn(rstn), .i_ctrl_reg0(ctrl_reg0), .i_ctrl_reg1(ctrl_reg1),
        .i_ar(ar), .i_r(r_beat), .i_r_ready(r_ready),
        .i_load(load_word), .i_network_done(network_done),
        .o_errors(chk_errors), .o_checked(chk_words)
    );

    // ------------------------------------------------------------------------
    // dram slave returning each beat's own byte address as data
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] addr;
        void'($urandom(73331));
        ar_ready = 1'b0;
        r_beat   = '0;
        forever begin
            @(negedge clk);
            if (ar.valid) begin
                repeat ($urandom_range(0, 3)) @(negedge clk);   // ready delay
                ar_ready = 1'b1;
                addr     = ar.addr;                             // held until accepted
                @(negedge clk);
                ar_ready = 1'b0;
                for (int beat = 0; beat < `BURST_LEN; beat++) begin
                    repeat ($urandom_range(0, 2)) @(negedge clk);   // beat gap
                    r_beat.valid = 1'b1;
                    r_beat.last  = (beat == `BURST_LEN - 1);
                    r_beat.data  = addr + 32'(BEAT_BYTES * beat);
                    @(negedge clk);
                    r_beat = '0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == TIMEOUT) begin
            $display("timeout after %0d cycles, network done never came", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic pulse_start(input logic [31:0] base);
        ctrl_reg1 = base;
        ctrl_reg0 = 32'h1;       // start bit
        @(negedge clk);
        ctrl_reg0 = '0;
    endtask

    task automatic wait_network_done();
        while (!network_done) @(negedge clk);
    endtask

    initial begin
        rstn      = 1'b0;
        ctrl_reg0 = '0;
        ctrl_reg1 = '0;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        repeat (10) @(negedge clk);          // idle with outputs low
        pulse_start(32'h1000_0000);
        repeat (100) @(negedge clk);
        pulse_start(32'h2000_0000);          // ignored while busy
        wait_network_done();
        repeat (20) @(negedge clk);          // done held
        pulse_start(32'h3400_0000);          // second run clears done
        wait_network_done();
        repeat (5) @(negedge clk);
        if (chk_words != 2 * RUN_WORDS) begin
            $display("FAIL %0t words_checked expected %0d got %0d",
                     $time, 2 * RUN_WORDS, chk_words);
            tb_errors++;
        end
        $display("errors %0d (checker %0d, testbench %0d), words checked %0d",
                 chk_errors + tb_errors, chk_errors, tb_errors, chk_words);
        if (chk_errors + tb_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
